// ==== ks10_defs.svh ====
/*
 * KS10 RAMFILE sizing constants
 * Depth, address and word widths of the scratch memory, plus the
 * stack pointer value that reset places in location 15
 */

`ifndef KS10_DEFS_SVH
`define KS10_DEFS_SVH

// 1K words of fast AC blocks and microcode workspace
`define RAMFILE_DEPTH 1024

// Address width for the 1K array
`define RAMFILE_AW 10

// PDP-10 word width
`define WORD_W 36

// Stack pointer preset in AC 15 of block 0
`define RAMFILE_SP_SEED 36'o777577030303

`endif

// ==== ks10_pkg.sv ====
/*
 * KS10 RAMFILE types
 * Word, address and AC field types, and the APB register offsets
 */

`default_nettype none

`include "ks10_defs.svh"

package ks10_pkg;

   // One PDP-10 word; KS10 bit 0 is the MSB at [35]
   typedef logic [`WORD_W-1:0] word36_t;

   // RAMFILE word address
   typedef logic [`RAMFILE_AW-1:0] ramfile_addr_t;

   // Current AC block, eight blocks of sixteen
   typedef logic [2:0] ac_block_t;

   // AC number within a block
   typedef logic [3:0] ac_num_t;

   // APB register byte offsets
   typedef enum logic [4:0] {
      REG_ADDR    = 5'h00,
      REG_BLOCK   = 5'h04,
      REG_DATA_LO = 5'h08,
      REG_DATA_HI = 5'h0C,
      REG_CMD     = 5'h10
   } ramfile_reg_e;

endpackage

`default_nettype wire

// ==== ramfile_if.sv ====
/*
 * RAMFILE port bundle
 * Enable, write, address and data lines between the controller,
 * the address former and the 1Kx36 array
 */

`timescale 1ns/1ps
`default_nettype none

interface ramfile_if import ks10_pkg::*; ();

   logic          clken;     // Operation on this edge
   logic          wr;        // Store din when enabled
   ramfile_addr_t ram_addr;  // Word address
   word36_t       din;       // Write data
   word36_t       dout;      // Word at last enabled address

   // Controller side, sequences the RAM cycle
   modport ctl (output clken, output wr, output din);

   // Address former side
   modport addr (output ram_addr);

   // Array side
   modport mem (input clken, input wr, input ram_addr, input din, output dout);

endinterface

`default_nettype wire

// ==== ram1kx36.sv ====
/*
 * RAM 1Kx36
 * Synchronous RAMFILE array with a registered read address.
 * Reset clears every word and presets the stack pointer at 15,
 * since microcode reads some locations before writing them.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ks10_defs.svh"

module ram1kx36 import ks10_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   ramfile_if.mem bus
);

   // Word storage
   word36_t       mem [`RAMFILE_DEPTH];

   // Address sampled on the last enabled edge
   ramfile_addr_t rd_addr;

   ////////////////////////////////////////////////////////////////////////////
   // Array write and read address register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < `RAMFILE_DEPTH; i++)
         begin
            mem[i] <= '0;
         end
         // Stack pointer lives in AC 15 of block 0
         mem[15] <= `RAMFILE_SP_SEED;
         rd_addr <= '0;
      end
      else if (bus.clken)
      begin
         if (bus.wr)
         begin
            mem[bus.ram_addr] <= bus.din;
         end
         rd_addr <= bus.ram_addr;
      end
   end

   // Read port follows the sampled address
   assign bus.dout = mem[rd_addr];

   // Address former must settle before any enabled edge
   a_addr_known: assert property (@(posedge clk) disable iff (rst)
      bus.clken |-> !$isunknown(bus.ram_addr));

endmodule

`default_nettype wire

// ==== ramfile_addr.sv ====
/*
 * RAMFILE address former
 * Selects the direct address or the AC address (block times
 * sixteen plus AC number) and holds it for the RAM cycle
 */

`timescale 1ns/1ps
`default_nettype none

module ramfile_addr import ks10_pkg::*;
(
   input  logic          clk,
   input  logic          rst,
   input  logic          ac_mode,
   input  ramfile_addr_t addr_field,
   input  ac_block_t     block,
   ramfile_if.addr       bus
);

   // AC number in the low bits of the field
   ac_num_t       ac_num;

   // Address chosen this cycle
   ramfile_addr_t next_addr;

   assign ac_num = addr_field[3:0];

   // AC blocks occupy 0 to 127, block in bits 6:4
   assign next_addr = ac_mode ? ramfile_addr_t'({block, ac_num}) : addr_field;

   ////////////////////////////////////////////////////////////////////////////
   // Address register
   ////////////////////////////////////////////////////////////////////////////

   // Fields only change between APB transfers, so the
   // register is settled before the command's RAM cycle
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         bus.ram_addr <= '0;
      end
      else
      begin
         bus.ram_addr <= next_addr;
      end
   end

endmodule

`default_nettype wire

// ==== ramfile_data.sv ====
/*
 * RAMFILE word staging register
 * Builds a 36-bit write word from the two APB halves and
 * takes the whole word from the array on a read capture
 */

`timescale 1ns/1ps
`default_nettype none

module ramfile_data import ks10_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        wr_lo,
   input  logic        wr_hi,
   input  logic [31:0] wdata,
   input  logic        capture,
   input  word36_t     rd_word,
   output word36_t     word
);

   ////////////////////////////////////////////////////////////////////////////
   // Staged word
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         word <= '0;
      end
      else if (capture)
      begin
         // Whole word from the array
         word <= rd_word;
      end
      else
      begin
         // KS10 bits 4 to 35
         if (wr_lo)
         begin
            word[31:0] <= wdata;
         end
         // KS10 bits 0 to 3
         if (wr_hi)
         begin
            word[35:32] <= wdata[3:0];
         end
      end
   end

   // Capture belongs to a command, half writes to register access
   a_no_overlap: assert property (@(posedge clk) disable iff (rst)
      capture |-> !(wr_lo || wr_hi));

endmodule

`default_nettype wire

// ==== ramfile_ctl.sv ====
/*
 * RAMFILE APB controller
 * Register decode, mode/address/block registers and the command
 * FSM that runs the RAM cycle and holds pready for wait states
 */

`timescale 1ns/1ps
`default_nettype none

module ramfile_ctl import ks10_pkg::*;
(
   input  logic          clk,
   input  logic          rst,
   input  logic          psel,
   input  logic          penable,
   input  logic          pwrite,
   input  logic [4:0]    paddr,
   input  logic [31:0]   pwdata,
   output logic [31:0]   prdata,
   output logic          pready,
   output logic          pslverr,
   input  word36_t       word,
   output logic          wr_lo,
   output logic          wr_hi,
   output logic          capture,
   output logic          ac_mode,
   output ramfile_addr_t addr_field,
   output ac_block_t     block,
   ramfile_if.ctl        bus
);

   typedef enum logic [1:0] {IDLE, RAM_CYCLE, CAPTURE, DONE} state_e;

   state_e       state;
   ramfile_reg_e reg_sel;
   logic         setup;
   logic         access;
   logic         reg_err;
   logic         cmd_start;
   logic         reg_wr;

   // APB phases
   assign setup  = psel & ~penable;
   assign access = psel & penable;

   assign reg_sel = ramfile_reg_e'(paddr);

   // Start bit set on a command write
   assign cmd_start = pwrite & (reg_sel == REG_CMD) & pwdata[0];

   // Error on unmapped offsets and command reads
   always_comb
   begin
      case (reg_sel)
         REG_ADDR, REG_BLOCK, REG_DATA_LO, REG_DATA_HI: reg_err = 1'b0;
         REG_CMD: reg_err = ~pwrite;
         default: reg_err = 1'b1;
      endcase
   end

   // Register writes land on the completing access cycle
   assign reg_wr = (state == DONE) & access & pwrite & ~pslverr;
   assign wr_lo  = reg_wr & (reg_sel == REG_DATA_LO);
   assign wr_hi  = reg_wr & (reg_sel == REG_DATA_HI);

   // Array always writes the staged word
   assign bus.din = word;

   ////////////////////////////////////////////////////////////////////////////
   // Read data mux
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      case (reg_sel)
         REG_ADDR:    prdata = {15'd0, ac_mode, 6'd0, addr_field};
         REG_BLOCK:   prdata = {29'd0, block};
         REG_DATA_LO: prdata = word[31:0];
         REG_DATA_HI: prdata = {28'd0, word[35:32]};
         default:     prdata = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Mode, address and block registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ac_mode    <= 1'b0;
         addr_field <= '0;
         block      <= '0;
      end
      else if (reg_wr)
      begin
         case (reg_sel)
            REG_ADDR:
            begin
               addr_field <= pwdata[9:0];
               ac_mode    <= pwdata[16];
            end
            REG_BLOCK: block <= pwdata[2:0];
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Command FSM
   ////////////////////////////////////////////////////////////////////////////

   // Decoded in setup so the first access cycle is already the
   // RAM cycle or the zero-wait completion
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state     <= IDLE;
         pready    <= 1'b0;
         pslverr   <= 1'b0;
         capture   <= 1'b0;
         bus.clken <= 1'b0;
         bus.wr    <= 1'b0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (setup && cmd_start)
               begin
                  state     <= RAM_CYCLE;
                  bus.clken <= 1'b1;
                  bus.wr    <= pwdata[1];
               end
               else if (setup)
               begin
                  state   <= DONE;
                  pready  <= 1'b1;
                  pslverr <= reg_err;
               end
            end
            RAM_CYCLE:
            begin
               bus.clken <= 1'b0;
               bus.wr    <= 1'b0;
               // Write finishes here while a read needs the array output
               if (bus.wr)
               begin
                  state  <= DONE;
                  pready <= 1'b1;
               end
               else
               begin
                  state   <= CAPTURE;
                  capture <= 1'b1;
               end
            end
            CAPTURE:
            begin
               capture <= 1'b0;
               pready  <= 1'b1;
               state   <= DONE;
            end
            default:
            begin
               pready  <= 1'b0;
               pslverr <= 1'b0;
               state   <= IDLE;
            end
         endcase
      end
   end

   // Completion only answers a live access phase
   a_pready_access: assert property (@(posedge clk) disable iff (rst)
      pready |-> psel && penable);

   // One enabled RAM edge within the access phase of a start command
   a_clken_pulse: assert property (@(posedge clk) disable iff (rst)
      bus.clken |-> access && cmd_start ##1 !bus.clken);

endmodule

`default_nettype wire

// ==== ramfile_top.sv ====
/*
 * KS10 RAMFILE subsystem
 * APB slave front end over the 1Kx36 scratch memory
 */

`timescale 1ns/1ps
`default_nettype none

module ramfile_top import ks10_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [4:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr
);

   // Staging strobes
   logic          wr_lo;
   logic          wr_hi;
   logic          capture;

   // Address fields from the register file
   logic          ac_mode;
   ramfile_addr_t addr_field;
   ac_block_t     block;

   // Staged word
   word36_t       word;

   // Shared RAM port
   ramfile_if bus ();

   ramfile_ctl u_ctl (
      .clk        (clk),
      .rst        (rst),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .word       (word),
      .wr_lo      (wr_lo),
      .wr_hi      (wr_hi),
      .capture    (capture),
      .ac_mode    (ac_mode),
      .addr_field (addr_field),
      .block      (block),
      .bus        (bus)
   );

   ramfile_addr u_addr (
      .clk        (clk),
      .rst        (rst),
      .ac_mode    (ac_mode),
      .addr_field (addr_field),
      .block      (block),
      .bus        (bus)
   );

   ramfile_data u_data (
      .clk     (clk),
      .rst     (rst),
      .wr_lo   (wr_lo),
      .wr_hi   (wr_hi),
      .wdata   (pwdata),
      .capture (capture),
      .rd_word (bus.dout),
      .word    (word)
   );

   ram1kx36 u_ram (
      .clk (clk),
      .rst (rst),
      .bus (bus)
   );

endmodule

`default_nettype wire

// ==== tb_ramfile.sv ====
/*
 * RAMFILE testbench
 * Table-driven APB traffic against a reference copy of the array,
 * with wait-state, error-response and staging checks
 */

`timescale 1ns/1ps
`default_nettype none

`include "ks10_defs.svh"

module tb_ramfile import ks10_pkg::*;
();

   // Row kinds
   localparam int OP_RD     = 0;
   localparam int OP_WR     = 1;
   localparam int OP_WR_LO  = 2;
   localparam int OP_NOP    = 3;
   localparam int OP_ERR_RD = 4;
   localparam int OP_ERR_WR = 5;
   localparam int MAX_ROWS  = 32;

   logic        clk;
   logic        rst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [4:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;

   // Stimulus table
   string       t_name [MAX_ROWS];
   int          t_op   [MAX_ROWS];
   bit          t_ac   [MAX_ROWS];
   logic [2:0]  t_blk  [MAX_ROWS];
   logic [9:0]  t_addr [MAX_ROWS];
   word36_t     t_data [MAX_ROWS];
   int          n_rows = 0;

   // Reference array and staging register model
   word36_t     ref_mem [`RAMFILE_DEPTH];
   word36_t     staged;

   logic [31:0] lfsr_state = 32'hd3f8b4e1;
   bit          timed_out  = 1'b0;
   bit          row_fail;
   int          passed     = 0;
   int          failed     = 0;

   ramfile_top dut (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   // 100 ns clock
   always #50 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
      begin
         return (s >> 1) ^ 32'h80200003;
      end
      return s >> 1;
   endfunction

   // One LFSR step per word bit
   function automatic word36_t rand_word();
      word36_t w;
      int      b;
      w = '0;
      for (b = 0; b < 36; b++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         w = {w[34:0], lfsr_state[0]};
      end
      return w;
   endfunction

   // Word index from the register map rules
   function automatic int ram_index(input bit ac, input logic [2:0] blk,
                                    input logic [9:0] a);
      if (ac)
      begin
         return int'(blk) * 16 + int'(a[3:0]);
      end
      return int'(a);
   endfunction

   task automatic add_row(input string name, input int op, input bit ac,
                          input logic [2:0] blk, input logic [9:0] a,
                          input word36_t data);
      t_name[n_rows] = name;
      t_op[n_rows]   = op;
      t_ac[n_rows]   = ac;
      t_blk[n_rows]  = blk;
      t_addr[n_rows] = a;
      t_data[n_rows] = data;
      n_rows++;
   endtask

   task automatic check_val(input string name, input string what,
                            input logic [35:0] exp, input logic [35:0] act);
      if (act !== exp)
      begin
         $display("[FAIL] %s %s expected %09h actual %09h", name, what, exp, act);
         row_fail = 1'b1;
      end
   endtask

   // One APB3 transfer, wait states counted from the first access cycle
   task automatic apb_xfer(input logic wr, input logic [4:0] off,
                           input logic [31:0] wd, output logic [31:0] rd,
                           output logic err, output int waits);
      bit done;
      int cyc;
      done  = 1'b0;
      waits = 0;
      rd    = '0;
      err   = 1'b0;
      if (!timed_out)
      begin
         @(posedge clk);
         psel    <= 1'b1;
         penable <= 1'b0;
         pwrite  <= wr;
         paddr   <= off;
         pwdata  <= wd;
         @(posedge clk);
         penable <= 1'b1;
         // Outputs sampled mid-cycle
         for (cyc = 0; cyc < 20 && !done; cyc++)
         begin
            @(negedge clk);
            if (pready)
            begin
               done = 1'b1;
               rd   = prdata;
               err  = pslverr;
            end
            else
            begin
               waits++;
            end
         end
         @(posedge clk);
         psel    <= 1'b0;
         penable <= 1'b0;
         if (!done)
         begin
            $display("Timeout: pready did not rise within 20 cycles, offset %02h", off);
            timed_out = 1'b1;
         end
      end
   endtask

   // Transfer plus response and wait-state checks
   task automatic reg_access(input string name, input logic wr, input logic [4:0] off,
                             input logic [31:0] wd, input logic exp_err,
                             input int exp_waits, output logic [31:0] rd);
      logic err;
      int   waits;
      apb_xfer(wr, off, wd, rd, err, waits);
      if (!timed_out)
      begin
         check_val(name, "pslverr", 36'(exp_err), 36'(err));
         check_val(name, "wait states", 36'(exp_waits), 36'(waits));
      end
   endtask

   task automatic set_addr(input string name, input bit ac, input logic [2:0] blk,
                           input logic [9:0] a);
      logic [31:0] rd;
      reg_access(name, 1'b1, REG_BLOCK, {29'd0, blk}, 1'b0, 0, rd);
      reg_access(name, 1'b1, REG_ADDR, {15'd0, ac, 6'd0, a}, 1'b0, 0, rd);
   endtask

   task automatic run_row(input int i);
      logic [31:0] rd;
      logic [31:0] lo;
      logic [31:0] hi;
      int          idx;
      idx = ram_index(t_ac[i], t_blk[i], t_addr[i]);
      case (t_op[i])
         OP_WR, OP_WR_LO, OP_NOP:
         begin
            set_addr(t_name[i], t_ac[i], t_blk[i], t_addr[i]);
            reg_access(t_name[i], 1'b1, REG_DATA_LO, t_data[i][31:0], 1'b0, 0, rd);
            staged[31:0] = t_data[i][31:0];
            // Low-only rows keep the earlier high bits
            if (t_op[i] != OP_WR_LO)
            begin
               reg_access(t_name[i], 1'b1, REG_DATA_HI, {28'd0, t_data[i][35:32]},
                          1'b0, 0, rd);
               staged[35:32] = t_data[i][35:32];
            end
            if (t_op[i] == OP_NOP)
            begin
               // Write bit without start bit
               reg_access(t_name[i], 1'b1, REG_CMD, 32'h2, 1'b0, 0, rd);
            end
            else
            begin
               reg_access(t_name[i], 1'b1, REG_CMD, 32'h3, 1'b0, 1, rd);
               ref_mem[idx] = staged;
            end
         end
         OP_RD:
         begin
            set_addr(t_name[i], t_ac[i], t_blk[i], t_addr[i]);
            reg_access(t_name[i], 1'b1, REG_CMD, 32'h1, 1'b0, 2, rd);
            // Capture replaces the whole staged word
            staged = ref_mem[idx];
            reg_access(t_name[i], 1'b0, REG_DATA_LO, 32'h0, 1'b0, 0, lo);
            reg_access(t_name[i], 1'b0, REG_DATA_HI, 32'h0, 1'b0, 0, hi);
            if (!timed_out)
            begin
               check_val(t_name[i], "word", ref_mem[idx], {hi[3:0], lo});
            end
         end
         OP_ERR_RD:
         begin
            reg_access(t_name[i], 1'b0, t_addr[i][4:0], 32'h0, 1'b1, 0, rd);
         end
         default:
         begin
            reg_access(t_name[i], 1'b1, t_addr[i][4:0], t_data[i][31:0], 1'b1, 0, rd);
         end
      endcase
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      clk     = 1'b0;
      rst     <= 1'b1;
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= '0;
      pwdata  <= '0;

      // Reset image of the array
      for (int k = 0; k < `RAMFILE_DEPTH; k++)
      begin
         ref_mem[k] = '0;
      end
      ref_mem[15] = `RAMFILE_SP_SEED;
      staged = '0;

      // Reset contents
      add_row("reset_sp_seed", OP_RD, 1'b0, 3'd0, 10'd15, '0);
      add_row("reset_loc0_zero", OP_RD, 1'b0, 3'd0, 10'd0, '0);
      // Direct words, top address included
      add_row("wr_direct_1", OP_WR, 1'b0, 3'd0, 10'd1, rand_word());
      add_row("wr_direct_517", OP_WR, 1'b0, 3'd0, 10'd517, rand_word());
      add_row("wr_direct_682", OP_WR, 1'b0, 3'd0, 10'd682, rand_word());
      add_row("wr_direct_1023", OP_WR, 1'b0, 3'd0, 10'd1023, rand_word());
      add_row("rd_direct_1", OP_RD, 1'b0, 3'd0, 10'd1, '0);
      add_row("rd_direct_517", OP_RD, 1'b0, 3'd0, 10'd517, '0);
      add_row("rd_direct_682", OP_RD, 1'b0, 3'd0, 10'd682, '0);
      add_row("rd_direct_1023", OP_RD, 1'b0, 3'd0, 10'd1023, '0);
      // Same AC number in two blocks, upper field bits ignored
      add_row("wr_ac_b3_n5", OP_WR, 1'b1, 3'd3, 10'h005, rand_word());
      add_row("wr_ac_b6_n5", OP_WR, 1'b1, 3'd6, 10'h0a5, rand_word());
      add_row("rd_ac_b3_n5_direct", OP_RD, 1'b0, 3'd0, 10'd53, '0);
      add_row("rd_ac_b6_n5_direct", OP_RD, 1'b0, 3'd0, 10'd101, '0);
      add_row("rd_ac_b3_n5", OP_RD, 1'b1, 3'd3, 10'h005, '0);
      // Staged high bits carry into a low-only write
      add_row("wr_full_300", OP_WR, 1'b0, 3'd0, 10'd300, rand_word());
      add_row("wr_lo_only_301", OP_WR_LO, 1'b0, 3'd0, 10'd301, rand_word());
      add_row("rd_lo_only_301", OP_RD, 1'b0, 3'd0, 10'd301, '0);
      add_row("rd_full_300", OP_RD, 1'b0, 3'd0, 10'd300, '0);
      // Command without start bit
      add_row("cmd_nop_300", OP_NOP, 1'b0, 3'd0, 10'd300, rand_word());
      add_row("rd_after_nop_300", OP_RD, 1'b0, 3'd0, 10'd300, '0);
      // Error responses, offset in the address column
      add_row("err_rd_unmapped", OP_ERR_RD, 1'b0, 3'd0, 10'h014, '0);
      add_row("err_wr_unmapped", OP_ERR_WR, 1'b0, 3'd0, 10'h01c, rand_word());
      add_row("err_rd_cmd", OP_ERR_RD, 1'b0, 3'd0, 10'(REG_CMD), '0);

      repeat (5) @(posedge clk);
      rst <= 1'b0;

      for (int i = 0; i < n_rows && !timed_out; i++)
      begin
         row_fail = 1'b0;
         run_row(i);
         if (row_fail || timed_out)
         begin
            failed++;
         end
         else
         begin
            passed++;
            $display("[PASS] %s", t_name[i]);
         end
      end

      $display("Tests run %0d, passed %0d, failed %0d", passed + failed, passed, failed);
      if (failed == 0 && !timed_out)
      begin
         $display("TEST OK");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
ks10_pkg.sv
ramfile_if.sv
ram1kx36.sv
ramfile_addr.sv
ramfile_data.sv
ramfile_ctl.sv
ramfile_top.sv
tb_ramfile.sv

// ==== Bender.yml ====
package:
  name: ks10_ramfile

export_include_dirs:
  - .

sources:
  - files:
      - ks10_pkg.sv
      - ramfile_if.sv
      - ram1kx36.sv
      - ramfile_addr.sv
      - ramfile_data.sv
      - ramfile_ctl.sv
      - ramfile_top.sv
  - target: test
    files:
      - tb_ramfile.sv
